// ==== Makefile ====
SIM  := obj_dir/Vperiph_tb
SRCS := $(shell cat periph_top.f)

.PHONY: all run clean

all: run

$(SIM): periph_top.f $(SRCS)
	verilator --binary --timing --assert --top-module periph_tb -f periph_top.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== logic/periph_bus_decoder.sv ====
// peripheral bus decoder: region select, strobe gating,
// response mux and the answer for unmapped addresses
`timescale 1ns/1ps

module periph_bus_decoder
(
	input  logic                clk,
	input  logic                reset,
	input  periph_pkg::wb_req_t req_i,
	output periph_pkg::wb_rsp_t rsp_o,
	output periph_pkg::wb_req_t irc_req_o,
	output periph_pkg::wb_req_t timer_req_o,
	output periph_pkg::wb_req_t uart_req_o,
	input  periph_pkg::wb_rsp_t irc_rsp_i,
	input  periph_pkg::wb_rsp_t timer_rsp_i,
	input  periph_pkg::wb_rsp_t uart_rsp_i
);
	import periph_pkg::*;

	logic [1:0] region;
	logic       unmapped_stb;
	logic       unmapped_ack;

	assign region = req_i.adr[13:12];

	// every slave sees the full request but only its own strobe
	always_comb
	begin
		irc_req_o       = req_i;
		timer_req_o     = req_i;
		uart_req_o      = req_i;
		irc_req_o.stb   = req_i.stb && (region == REGION_IRC);
		timer_req_o.stb = req_i.stb && (region == REGION_TIMER);
		uart_req_o.stb  = req_i.stb && (region == REGION_UART);
	end

	assign unmapped_stb = req_i.stb && (region == 2'd3);

	// single ack pulse for region 3
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			unmapped_ack <= 1'b0;
		end
		else
		begin
			unmapped_ack <= unmapped_stb && !unmapped_ack;
		end
	end

	// address is held until ack, so the mux can follow it directly
	always_comb
	begin
		case (region)
			REGION_IRC:   rsp_o = irc_rsp_i;
			REGION_TIMER: rsp_o = timer_rsp_i;
			REGION_UART:  rsp_o = uart_rsp_i;
			default:
			begin
				rsp_o.dat = 32'h0;
				rsp_o.ack = unmapped_ack;
			end
		endcase
	end

	// only the addressed slave or the unmapped responder answers
	a_one_ack: assert property (@(posedge clk) disable iff (reset)
		$onehot0({irc_rsp_i.ack, timer_rsp_i.ack, uart_rsp_i.ack, unmapped_ack}));

endmodule

// ==== logic/periph_irc.sv ====
// interrupt controller: enable mask, lowest-number priority,
// request/acknowledge to the CPU and end-of-interrupt
`timescale 1ns/1ps

module periph_irc
(
	input  logic                       clk,
	input  logic                       reset,
	input  periph_pkg::wb_req_t        bus_req_i,
	output periph_pkg::wb_rsp_t        bus_rsp_o,
	input  logic [periph_pkg::IRQ_NUM-1:0] irq_src_i,
	output logic                       irq_o,
	input  logic                       irq_ack_i
);
	import periph_pkg::*;

	localparam int FACTOR_W = $clog2(IRQ_NUM);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQUEST,
		ST_SERVICE
	} irc_state_t;

	irc_state_t          state;
	logic [IRQ_NUM-1:0]  enable_q;
	logic [IRQ_NUM-1:0]  pending;
	logic [FACTOR_W-1:0] factor_q;
	logic                ack_q;
	logic [31:0]         rdata_q;
	logic                access;
	logic                wr_en;
	logic                eoi_wr;

	// lowest set bit of the request vector
	function automatic logic [FACTOR_W-1:0] lowest_factor(input logic [IRQ_NUM-1:0] req);
		logic [FACTOR_W-1:0] idx;
		idx = '0;
		for (int i = IRQ_NUM - 1; i >= 0; i--)
		begin
			if (req[i])
			begin
				idx = FACTOR_W'(i);
			end
		end
		return idx;
	endfunction

	// ------------------------------
	// register access
	// ------------------------------

	assign access = bus_req_i.stb && !ack_q;
	assign wr_en  = access && bus_req_i.we;
	assign eoi_wr = wr_en && (bus_req_i.adr[1:0] == IRC_REG_EOI);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ack_q    <= 1'b0;
			rdata_q  <= 32'h0;
			enable_q <= '0;
		end
		else
		begin
			ack_q <= access;
			if (wr_en && bus_req_i.sel[0] && (bus_req_i.adr[1:0] == IRC_REG_ENABLE))
			begin
				enable_q <= bus_req_i.dat[IRQ_NUM-1:0];
			end
			if (access)
			begin
				case (bus_req_i.adr[1:0])
					IRC_REG_ENABLE:  rdata_q <= 32'(enable_q);
					IRC_REG_PENDING: rdata_q <= 32'(pending);
					IRC_REG_FACTOR:  rdata_q <= 32'(factor_q);
					default:         rdata_q <= 32'h0;
				endcase
			end
		end
	end

	assign bus_rsp_o.ack = ack_q;
	assign bus_rsp_o.dat = rdata_q;

	// ------------------------------
	// request state machine
	// ------------------------------

	assign pending = irq_src_i & enable_q;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state    <= ST_IDLE;
			factor_q <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (|pending)
					begin
						state    <= ST_REQUEST;
						factor_q <= lowest_factor(pending);
					end
				end
				ST_REQUEST:
				begin
					if (irq_ack_i)
					begin
						state <= ST_SERVICE;
					end
				end
				ST_SERVICE:
				begin
					// software signals the handler is done
					if (eoi_wr)
					begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign irq_o = (state == ST_REQUEST);

	// request is held until the CPU acknowledges it
	a_irq_held: assert property (@(posedge clk) disable iff (reset)
		irq_o && !irq_ack_i |=> irq_o);

endmodule

// ==== logic/periph_pkg.sv ====
// shared bus structs, address map regions, register offsets
// and interrupt factor numbering for the peripheral subsystem

package periph_pkg;

	// ------------------------------
	// bus request and response
	// ------------------------------

	// word address, region in [13:12], register offset in [1:0]
	typedef struct packed {
		logic [13:0] adr;
		logic [31:0] dat;
		logic        we;
		logic [3:0]  sel;
		logic        stb;
	} wb_req_t;

	typedef struct packed {
		logic [31:0] dat;
		logic        ack;
	} wb_rsp_t;

	// ------------------------------
	// address map
	// ------------------------------

	localparam logic [1:0] REGION_IRC   = 2'd0;
	localparam logic [1:0] REGION_TIMER = 2'd1;
	localparam logic [1:0] REGION_UART  = 2'd2;

	localparam logic [1:0] IRC_REG_ENABLE  = 2'd0;
	localparam logic [1:0] IRC_REG_PENDING = 2'd1;
	localparam logic [1:0] IRC_REG_FACTOR  = 2'd2;
	localparam logic [1:0] IRC_REG_EOI     = 2'd3;

	localparam logic [1:0] TIMER_REG_CTRL    = 2'd0;
	localparam logic [1:0] TIMER_REG_COMPARE = 2'd1;
	localparam logic [1:0] TIMER_REG_COUNT   = 2'd2;
	localparam logic [1:0] TIMER_REG_STATUS  = 2'd3;

	localparam logic [1:0] UART_REG_DATA   = 2'd0;
	localparam logic [1:0] UART_REG_STATUS = 2'd1;

	// interrupt factors, lowest number wins
	localparam int IRQ_NUM       = 3;
	localparam int IRQ_TIMER     = 0;
	localparam int IRQ_UART_IDLE = 1;
	localparam int IRQ_SPARE     = 2;

endpackage

// ==== logic/periph_timer.sv ====
// compare timer: free-running count that wraps at compare
// and sets a sticky expired flag
`timescale 1ns/1ps

module periph_timer
#(
	parameter int TIMER_WIDTH = 16
)
(
	input  logic                clk,
	input  logic                reset,
	input  periph_pkg::wb_req_t bus_req_i,
	output periph_pkg::wb_rsp_t bus_rsp_o,
	output logic                irq_o
);
	import periph_pkg::*;

	logic                   enable_q;
	logic                   expired_q;
	logic [TIMER_WIDTH-1:0] compare_q;
	logic [TIMER_WIDTH-1:0] count_q;
	logic                   ack_q;
	logic [31:0]            rdata_q;
	logic                   access;
	logic                   wr_en;
	logic [1:0]             reg_sel;

	assign access  = bus_req_i.stb && !ack_q;
	assign wr_en   = access && bus_req_i.we;
	assign reg_sel = bus_req_i.adr[1:0];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ack_q     <= 1'b0;
			rdata_q   <= 32'h0;
			enable_q  <= 1'b0;
			expired_q <= 1'b0;
			compare_q <= '1;
			count_q   <= '0;
		end
		else
		begin
			ack_q <= access;
			if (wr_en && bus_req_i.sel[0] && (reg_sel == TIMER_REG_CTRL))
			begin
				enable_q <= bus_req_i.dat[0];
			end
			// write one to clear, a same-cycle expiry below wins
			if (wr_en && bus_req_i.sel[0] && (reg_sel == TIMER_REG_STATUS) && bus_req_i.dat[0])
			begin
				expired_q <= 1'b0;
			end
			if (wr_en && (reg_sel == TIMER_REG_COMPARE))
			begin
				for (int i = 0; i < TIMER_WIDTH; i++)
				begin
					if (bus_req_i.sel[i/8])
					begin
						compare_q[i] <= bus_req_i.dat[i];
					end
				end
				// new compare restarts the period
				count_q <= '0;
			end
			else if (enable_q)
			begin
				if (count_q == compare_q)
				begin
					count_q   <= '0;
					expired_q <= 1'b1;
				end
				else
				begin
					count_q <= count_q + 1'b1;
				end
			end
			if (access)
			begin
				case (reg_sel)
					TIMER_REG_CTRL:    rdata_q <= 32'(enable_q);
					TIMER_REG_COMPARE: rdata_q <= 32'(compare_q);
					TIMER_REG_COUNT:   rdata_q <= 32'(count_q);
					default:           rdata_q <= 32'(expired_q);
				endcase
			end
		end
	end

	assign bus_rsp_o.ack = ack_q;
	assign bus_rsp_o.dat = rdata_q;
	assign irq_o         = expired_q;

	a_count_in_range: assert property (@(posedge clk) disable iff (reset)
		enable_q |-> (count_q <= compare_q));

endmodule

// ==== logic/periph_top.sv ====
// peripheral subsystem top: bus decoder, interrupt controller,
// timer and UART transmitter
`timescale 1ns/1ps

module periph_top
#(
	parameter int TX_FIFO_PTR_WIDTH = 2,
	parameter int UART_CLK_DIV      = 8,
	parameter int TIMER_WIDTH       = 16
)
(
	input  logic                clk,
	input  logic                reset,
	input  periph_pkg::wb_req_t wb_req_i,
	output periph_pkg::wb_rsp_t wb_rsp_o,
	output logic                irq_o,
	input  logic                irq_ack_i,
	output logic                uart_tx_o
);
	import periph_pkg::*;

	wb_req_t            irc_req;
	wb_req_t            timer_req;
	wb_req_t            uart_req;
	wb_rsp_t            irc_rsp;
	wb_rsp_t            timer_rsp;
	wb_rsp_t            uart_rsp;
	logic               timer_irq;
	logic               uart_idle_irq;
	logic [IRQ_NUM-1:0] irq_src;

	// interrupt factor map
	assign irq_src[IRQ_TIMER]     = timer_irq;
	assign irq_src[IRQ_UART_IDLE] = uart_idle_irq;
	assign irq_src[IRQ_SPARE]     = 1'b0;

	periph_bus_decoder i_bus_decoder
	(
		.clk         (clk),
		.reset       (reset),
		.req_i       (wb_req_i),
		.rsp_o       (wb_rsp_o),
		.irc_req_o   (irc_req),
		.timer_req_o (timer_req),
		.uart_req_o  (uart_req),
		.irc_rsp_i   (irc_rsp),
		.timer_rsp_i (timer_rsp),
		.uart_rsp_i  (uart_rsp)
	);

	periph_irc i_irc
	(
		.clk       (clk),
		.reset     (reset),
		.bus_req_i (irc_req),
		.bus_rsp_o (irc_rsp),
		.irq_src_i (irq_src),
		.irq_o     (irq_o),
		.irq_ack_i (irq_ack_i)
	);

	periph_timer #(
		.TIMER_WIDTH (TIMER_WIDTH)
	) i_timer
	(
		.clk       (clk),
		.reset     (reset),
		.bus_req_i (timer_req),
		.bus_rsp_o (timer_rsp),
		.irq_o     (timer_irq)
	);

	periph_uart_tx #(
		.TX_FIFO_PTR_WIDTH (TX_FIFO_PTR_WIDTH),
		.UART_CLK_DIV      (UART_CLK_DIV)
	) i_uart_tx
	(
		.clk        (clk),
		.reset      (reset),
		.bus_req_i  (uart_req),
		.bus_rsp_o  (uart_rsp),
		.uart_tx_o  (uart_tx_o),
		.irq_idle_o (uart_idle_irq)
	);

endmodule

// ==== logic/periph_uart_tx.sv ====
// transmit-only UART: byte FIFO, baud divider, 8N1 shifter
// and status register
`timescale 1ns/1ps

module periph_uart_tx
#(
	parameter int TX_FIFO_PTR_WIDTH = 2,
	parameter int UART_CLK_DIV      = 8
)
(
	input  logic                clk,
	input  logic                reset,
	input  periph_pkg::wb_req_t bus_req_i,
	output periph_pkg::wb_rsp_t bus_rsp_o,
	output logic                uart_tx_o,
	output logic                irq_idle_o
);
	import periph_pkg::*;

	localparam int DEPTH = 2 ** TX_FIFO_PTR_WIDTH;
	localparam int DIV_W = $clog2(UART_CLK_DIV);

	logic [7:0]                   fifo_mem [DEPTH];
	logic [TX_FIFO_PTR_WIDTH-1:0] wr_ptr_q;
	logic [TX_FIFO_PTR_WIDTH-1:0] rd_ptr_q;
	logic [TX_FIFO_PTR_WIDTH:0]   count_q;
	logic                         full;
	logic                         empty;
	logic                         push;
	logic                         pop;
	logic [DIV_W-1:0]             baud_cnt_q;
	logic                         baud_tick;
	logic [9:0]                   shift_q;
	logic [3:0]                   bit_cnt_q;
	logic                         busy;
	logic                         tx_q;
	logic                         ack_q;
	logic [31:0]                  rdata_q;
	logic [31:0]                  status;
	logic                         access;

	// ------------------------------
	// bus side
	// ------------------------------

	assign access = bus_req_i.stb && !ack_q;
	assign push   = access && bus_req_i.we && bus_req_i.sel[0]
	              && (bus_req_i.adr[1:0] == UART_REG_DATA) && !full;

	always_comb
	begin
		status                              = 32'h0;
		status[0]                           = full;
		status[1]                           = busy;
		status[8 +: TX_FIFO_PTR_WIDTH + 1]  = count_q;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ack_q   <= 1'b0;
			rdata_q <= 32'h0;
		end
		else
		begin
			ack_q <= access;
			if (access)
			begin
				rdata_q <= (bus_req_i.adr[1:0] == UART_REG_STATUS) ? status : 32'h0;
			end
		end
	end

	assign bus_rsp_o.ack = ack_q;
	assign bus_rsp_o.dat = rdata_q;

	// ------------------------------
	// transmit FIFO
	// ------------------------------

	assign full  = (count_q == (TX_FIFO_PTR_WIDTH + 1)'(DEPTH));
	assign empty = (count_q == '0);

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			fifo_mem[wr_ptr_q] <= bus_req_i.dat[7:0];
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else
		begin
			if (push)
			begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop)
			begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			if (push && !pop)
			begin
				count_q <= count_q + 1'b1;
			end
			else if (pop && !push)
			begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	// ------------------------------
	// baud divider and shifter
	// ------------------------------

	assign baud_tick = (baud_cnt_q == DIV_W'(UART_CLK_DIV - 1));
	assign busy      = (bit_cnt_q != 4'd0);
	assign pop       = baud_tick && !busy && !empty;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			baud_cnt_q <= '0;
		end
		else
		begin
			baud_cnt_q <= baud_tick ? '0 : baud_cnt_q + 1'b1;
		end
	end

	// stop, data LSB first, start; ones shift in behind
	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			shift_q <= {1'b1, fifo_mem[rd_ptr_q], 1'b0};
		end
		else if (baud_tick && busy)
		begin
			shift_q <= {1'b1, shift_q[9:1]};
		end
	end

	// 10 bits on the line plus one tick to close the stop bit
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			bit_cnt_q <= 4'd0;
			tx_q      <= 1'b1;
		end
		else if (pop)
		begin
			bit_cnt_q <= 4'd11;
		end
		else if (baud_tick && busy)
		begin
			tx_q      <= shift_q[0];
			bit_cnt_q <= bit_cnt_q - 1'b1;
		end
	end

	assign uart_tx_o  = tx_q;
	assign irq_idle_o = empty && !busy;

	a_fifo_count: assert property (@(posedge clk) disable iff (reset)
		count_q <= (TX_FIFO_PTR_WIDTH + 1)'(DEPTH));

endmodule

// ==== periph_top.f ====
logic/periph_pkg.sv
logic/periph_bus_decoder.sv
logic/periph_irc.sv
logic/periph_timer.sv
logic/periph_uart_tx.sv
logic/periph_top.sv
verif/periph_tb.sv

// ==== verif/periph_tb.sv ====
// testbench for the peripheral subsystem: clock, reset, bus tasks,
// UART line monitor and assertion checks
`timescale 1ns/1ps

module periph_tb;
	import periph_pkg::*;

	localparam int TX_FIFO_PTR_WIDTH = 2;
	localparam int UART_CLK_DIV      = 8;
	localparam int TIMER_WIDTH       = 16;
	localparam int DEPTH             = 2 ** TX_FIFO_PTR_WIDTH;
	localparam int ACK_TIMEOUT       = 20;
	localparam int IRQ_TIMEOUT       = 200;
	localparam int POLL_LIMIT        = 400;

	logic        clk;
	logic        reset;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	logic        irq;
	logic        irq_ack;
	logic        uart_tx;

	int          seed = 50;
	int          mismatches = 0;
	int          timeouts = 0;
	int unsigned cycle = 0;
	int unsigned last_change = 0;
	logic        seen_change = 1'b0;
	logic        tx_prev = 1'b1;
	logic        in_service;
	logic        mask_off;
	logic [7:0]  tx_expect[$];
	logic [7:0]  rx_got[$];
	logic [31:0] rdata;
	logic [31:0] value;
	logic [31:0] compare_val;
	int unsigned t_clear;
	int unsigned t_set;

	periph_top #(
		.TX_FIFO_PTR_WIDTH (TX_FIFO_PTR_WIDTH),
		.UART_CLK_DIV      (UART_CLK_DIV),
		.TIMER_WIDTH       (TIMER_WIDTH)
	) u_dut
	(
		.clk       (clk),
		.reset     (reset),
		.wb_req_i  (wb_req),
		.wb_rsp_o  (wb_rsp),
		.irq_o     (irq),
		.irq_ack_i (irq_ack),
		.uart_tx_o (uart_tx)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------
	// reporting and bus helpers
	// ------------------------------

	task automatic report_mismatch(input string msg);
		mismatches++;
		$display("mismatch at %0t ns: %s", $time, msg);
	endtask

	task automatic report_timeout(input string msg);
		timeouts++;
		$display("timeout at %0t ns: %s", $time, msg);
	endtask

	function automatic logic [13:0] reg_addr(input logic [1:0] region, input logic [1:0] offset);
		return {region, 10'b0, offset};
	endfunction

	// waits for the ack of the request already on the bus
	task automatic wait_ack(input string what);
		int waited;
		waited = 0;
		do
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		while (!wb_rsp.ack && waited < ACK_TIMEOUT);
		if (!wb_rsp.ack)
		begin
			report_timeout($sformatf("no ack for %s", what));
		end
	endtask

	task automatic bus_write(input logic [13:0] adr, input logic [31:0] dat);
		@(posedge clk);
		#1;
		wb_req.adr = adr;
		wb_req.dat = dat;
		wb_req.we  = 1'b1;
		wb_req.sel = 4'hf;
		wb_req.stb = 1'b1;
		wait_ack($sformatf("write to %h", adr));
		wb_req.stb = 1'b0;
		wb_req.we  = 1'b0;
	endtask

	task automatic bus_read(input logic [13:0] adr, output logic [31:0] dat);
		@(posedge clk);
		#1;
		wb_req.adr = adr;
		wb_req.we  = 1'b0;
		wb_req.sel = 4'hf;
		wb_req.stb = 1'b1;
		wait_ack($sformatf("read of %h", adr));
		dat        = wb_rsp.dat;
		wb_req.stb = 1'b0;
	endtask

	// polls count and status until the expired bit shows up
	task automatic wait_timer_expiry(output int unsigned seen_at);
		logic [31:0] count;
		logic [31:0] status;
		int          polls;
		polls  = 0;
		status = 32'h0;
		while (!status[0] && polls < POLL_LIMIT)
		begin
			bus_read(reg_addr(REGION_TIMER, TIMER_REG_COUNT), count);
			assert (count <= compare_val)
			else report_mismatch($sformatf("timer count %0d above compare %0d", count, compare_val));
			bus_read(reg_addr(REGION_TIMER, TIMER_REG_STATUS), status);
			polls++;
		end
		seen_at = cycle;
		if (!status[0])
		begin
			report_timeout("timer expired bit never set");
		end
	endtask

	task automatic take_irq(input int expect_factor);
		logic [31:0] factor;
		int          waited;
		waited = 0;
		while (!irq && waited < IRQ_TIMEOUT)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!irq)
		begin
			report_timeout("irq_o never rose");
		end
		irq_ack = 1'b1;
		@(posedge clk);
		#1;
		irq_ack    = 1'b0;
		in_service = 1'b1;
		bus_read(reg_addr(REGION_IRC, IRC_REG_FACTOR), factor);
		assert (factor == 32'(expect_factor))
		else report_mismatch($sformatf("factor %0d, expected %0d", factor, expect_factor));
	endtask

	// new mask first, then end of interrupt
	task automatic finish_irq(input logic [31:0] new_mask);
		bus_write(reg_addr(REGION_IRC, IRC_REG_ENABLE), new_mask);
		bus_write(reg_addr(REGION_IRC, IRC_REG_EOI), 32'h1);
		in_service = 1'b0;
	endtask

	// wait for an empty FIFO and idle shifter, then compare bytes
	task automatic compare_uart_bytes;
		logic [31:0] status;
		logic [7:0]  exp_b;
		logic [7:0]  got_b;
		int          polls;
		polls  = 0;
		status = 32'hffff_ffff;
		while ((status[1] || status[8 +: TX_FIFO_PTR_WIDTH + 1] != '0) && polls < POLL_LIMIT)
		begin
			bus_read(reg_addr(REGION_UART, UART_REG_STATUS), status);
			polls++;
		end
		if (status[1] || status[8 +: TX_FIFO_PTR_WIDTH + 1] != '0)
		begin
			report_timeout("uart transmitter never went idle");
		end
		assert (rx_got.size() == tx_expect.size())
		else report_mismatch($sformatf("uart sent %0d bytes, expected %0d",
			rx_got.size(), tx_expect.size()));
		while (tx_expect.size() > 0 && rx_got.size() > 0)
		begin
			exp_b = tx_expect.pop_front();
			got_b = rx_got.pop_front();
			assert (got_b == exp_b)
			else report_mismatch($sformatf("uart byte %h, expected %h", got_b, exp_b));
		end
		tx_expect.delete();
		rx_got.delete();
	endtask

	// ------------------------------
	// protocol checks
	// ------------------------------

	a_ack_after_stb: assert property (@(posedge clk) disable iff (reset)
		$rose(wb_req.stb) |=> wb_rsp.ack)
	else report_mismatch("no ack one cycle after stb");

	a_ack_single: assert property (@(posedge clk) disable iff (reset)
		wb_rsp.ack |=> !wb_rsp.ack)
	else report_mismatch("ack longer than one cycle");

	a_ack_needs_stb: assert property (@(posedge clk) disable iff (reset)
		wb_rsp.ack |-> $past(wb_req.stb))
	else report_mismatch("ack without stb");

	a_quiet_in_service: assert property (@(posedge clk) disable iff (reset)
		in_service |-> !irq)
	else report_mismatch("irq_o high while in service");

	a_quiet_masked: assert property (@(posedge clk) disable iff (reset)
		mask_off |-> !irq)
	else report_mismatch("irq_o high with mask cleared");

	// line only moves on baud ticks
	always @(posedge clk)
	begin
		cycle   <= cycle + 1;
		tx_prev <= uart_tx;
		if (!reset && (uart_tx !== tx_prev))
		begin
			if (seen_change)
			begin
				assert ((cycle - last_change) % UART_CLK_DIV == 0)
				else report_mismatch($sformatf("uart edge after %0d cycles", cycle - last_change));
			end
			seen_change <= 1'b1;
			last_change <= cycle;
		end
	end

	// samples each bit at its centre
	initial
	begin : uart_monitor
		logic [7:0] rx_byte;
		forever
		begin
			@(posedge clk);
			#1;
			if (!reset && uart_tx == 1'b0)
			begin
				repeat (UART_CLK_DIV / 2) @(posedge clk);
				#1;
				assert (uart_tx == 1'b0)
				else report_mismatch("uart start bit not low at centre");
				for (int i = 0; i < 8; i++)
				begin
					repeat (UART_CLK_DIV) @(posedge clk);
					#1;
					rx_byte[i] = uart_tx;
				end
				repeat (UART_CLK_DIV) @(posedge clk);
				#1;
				assert (uart_tx == 1'b1)
				else report_mismatch("uart stop bit not high");
				rx_got.push_back(rx_byte);
			end
		end
	end

	// ------------------------------
	// stimulus
	// ------------------------------

	initial
	begin : stimulus
		logic [7:0] b;
		int         polls;
		reset      = 1'b1;
		wb_req     = '0;
		irq_ack    = 1'b0;
		in_service = 1'b0;
		mask_off   = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		// register read back and unmapped region
		bus_write(reg_addr(REGION_IRC, IRC_REG_ENABLE), 32'h5);
		bus_read(reg_addr(REGION_IRC, IRC_REG_ENABLE), rdata);
		assert (rdata == 32'h5) else report_mismatch($sformatf("enable read %h", rdata));
		bus_write(reg_addr(REGION_IRC, IRC_REG_ENABLE), 32'h0);
		value = 32'($random(seed)) & 32'hffff;
		bus_write(reg_addr(REGION_TIMER, TIMER_REG_COMPARE), value);
		bus_read(reg_addr(REGION_TIMER, TIMER_REG_COMPARE), rdata);
		assert (rdata == value) else report_mismatch($sformatf("compare read %h", rdata));
		bus_write(reg_addr(2'd3, 2'd1), 32'hdead_beef);
		bus_read(reg_addr(2'd3, 2'd2), rdata);
		assert (rdata == 32'h0) else report_mismatch($sformatf("unmapped read %h", rdata));

		// timer period
		compare_val = 32'd20 + (32'($random(seed)) & 32'h1f);
		bus_write(reg_addr(REGION_TIMER, TIMER_REG_COMPARE), compare_val);
		bus_write(reg_addr(REGION_TIMER, TIMER_REG_CTRL), 32'h1);
		wait_timer_expiry(t_set);
		bus_write(reg_addr(REGION_TIMER, TIMER_REG_CTRL), 32'h0);
		bus_write(reg_addr(REGION_TIMER, TIMER_REG_COMPARE), compare_val);
		bus_write(reg_addr(REGION_TIMER, TIMER_REG_STATUS), 32'h1);
		t_clear = cycle;
		bus_write(reg_addr(REGION_TIMER, TIMER_REG_CTRL), 32'h1);
		wait_timer_expiry(t_set);
		assert (t_set - t_clear >= compare_val + 1)
		else report_mismatch($sformatf("expiry %0d cycles after clear", t_set - t_clear));

		// interrupt flow, then an expiry with the mask cleared
		bus_write(reg_addr(REGION_IRC, IRC_REG_ENABLE), 32'(1) << IRQ_TIMER);
		take_irq(IRQ_TIMER);
		finish_irq(32'h0);
		mask_off = 1'b1;
		bus_write(reg_addr(REGION_TIMER, TIMER_REG_STATUS), 32'h1);
		wait_timer_expiry(t_set);
		bus_read(reg_addr(REGION_IRC, IRC_REG_PENDING), rdata);
		assert (rdata == 32'h0) else report_mismatch($sformatf("masked pending %h", rdata));
		mask_off = 1'b0;

		// priority between timer and uart idle
		bus_write(reg_addr(REGION_IRC, IRC_REG_ENABLE),
			(32'(1) << IRQ_TIMER) | (32'(1) << IRQ_UART_IDLE));
		bus_read(reg_addr(REGION_IRC, IRC_REG_PENDING), rdata);
		assert (rdata == 32'h3) else report_mismatch($sformatf("pending %h", rdata));
		take_irq(IRQ_TIMER);
		finish_irq(32'(1) << IRQ_UART_IDLE);
		take_irq(IRQ_UART_IDLE);
		finish_irq(32'h0);
		bus_write(reg_addr(REGION_TIMER, TIMER_REG_CTRL), 32'h0);

		// uart bytes in order
		for (int i = 0; i < 3; i++)
		begin
			b = 8'($random(seed));
			tx_expect.push_back(b);
			bus_write(reg_addr(REGION_UART, UART_REG_DATA), 32'(b));
		end
		compare_uart_bytes();

		// fill the FIFO behind a busy shifter and drop the extra bytes
		b = 8'($random(seed));
		tx_expect.push_back(b);
		bus_write(reg_addr(REGION_UART, UART_REG_DATA), 32'(b));
		polls = 0;
		rdata = 32'h0;
		while (!rdata[1] && polls < POLL_LIMIT)
		begin
			bus_read(reg_addr(REGION_UART, UART_REG_STATUS), rdata);
			polls++;
		end
		if (!rdata[1])
		begin
			report_timeout("uart shifter never became busy");
		end
		for (int i = 0; i < DEPTH + 2; i++)
		begin
			b = 8'($random(seed));
			if (i < DEPTH)
			begin
				tx_expect.push_back(b);
			end
			bus_write(reg_addr(REGION_UART, UART_REG_DATA), 32'(b));
			if (i == DEPTH - 1)
			begin
				bus_read(reg_addr(REGION_UART, UART_REG_STATUS), rdata);
				assert (rdata[0] && rdata[8 +: TX_FIFO_PTR_WIDTH + 1] == (TX_FIFO_PTR_WIDTH + 1)'(DEPTH))
				else report_mismatch($sformatf("uart status %h with full FIFO", rdata));
			end
		end
		compare_uart_bytes();

		$display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
		begin
			$display("** PASS **");
		end
		else
		begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule
